// File: burst_counter.sv
`timescale 1ns/1ns

module burst_counter (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear,
  input  logic [tcdm_pkg::AW-1:0]      start_addr,
  input  logic [ctrl_pkg::LEN_W-1:0]   len,
  input  logic                         beat_fire,
  input  logic                         rsp_fire,
  output logic [tcdm_pkg::AW-1:0]      beat_addr,
  output logic [ctrl_pkg::LEN_W-1:0]   beat_idx,
  output logic                         issue_done,
  output logic                         drain_done
);

  // Granted beats and received responses of the current burst
  logic [ctrl_pkg::CNT_W-1:0] issue_q;
  logic [ctrl_pkg::CNT_W-1:0] rsp_q;
  logic [ctrl_pkg::CNT_W-1:0] beats;
  logic [ctrl_pkg::CNT_W-1:0] rsp_next;
  logic [tcdm_pkg::AW-1:0]    issue_ext;

  // Total beat count, len holds the count minus one
  assign beats = {1'b0, len} + {{(ctrl_pkg::CNT_W-1){1'b0}}, 1'b1};

  // ####################
  // Counters
  // ####################

  // Both counts move on the edge after the event they count
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_q <= '0;
      rsp_q   <= '0;
    end else if (clear) begin
      issue_q <= '0;
      rsp_q   <= '0;
    end else begin
      if (beat_fire) begin
        issue_q <= issue_q + 1'b1;
      end
      if (rsp_fire) begin
        rsp_q <= rsp_next;
      end
    end
  end

  // ####################
  // Outputs
  // ####################

  // Address wraps naturally at the top of the bank
  assign issue_ext = {{(tcdm_pkg::AW-ctrl_pkg::CNT_W){1'b0}}, issue_q};
  assign beat_addr = start_addr + issue_ext;
  assign beat_idx  = issue_q[ctrl_pkg::LEN_W-1:0];

  // All beats granted, the request must drop
  assign issue_done = (issue_q == beats);

  // Count the response arriving in this cycle too, so the engine can leave
  // its drain state on the cycle after the last response
  assign rsp_next   = rsp_q + {{(ctrl_pkg::CNT_W-1){1'b0}}, rsp_fire};
  assign drain_done = (rsp_next == beats);

endmodule

// File: burst_fsm.sv
`timescale 1ns/1ns

module burst_fsm (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  ctrl_pkg::cmd_t             cmd,
  input  logic                       cmd_req,
  output logic                       cmd_ack,
  output ctrl_pkg::res_t             res,
  output tcdm_pkg::tcdm_req_t        tcdm_req,
  input  tcdm_pkg::tcdm_rsp_t        tcdm_rsp,
  output logic                       cnt_clear,
  output logic                       filt_clear,
  output logic                       filt_enable,
  output logic                       beat_fire,
  output logic                       rsp_fire,
  input  logic [tcdm_pkg::AW-1:0]    beat_addr,
  input  logic [ctrl_pkg::LEN_W-1:0] beat_idx,
  input  logic                       issue_done,
  input  logic                       drain_done
);

  ctrl_pkg::fsm_state_e state_q;
  ctrl_pkg::fsm_state_e state_d;
  ctrl_pkg::cmd_t       cmd_q;
  ctrl_pkg::res_t       res_q;
  logic                 cmd_ack_q;
  logic                 start;
  logic                 is_sum;
  logic                 last_beat;

  // A command is accepted only from IDLE
  assign start  = (state_q == ctrl_pkg::IDLE) && cmd_req;
  assign is_sum = (cmd_q.op == ctrl_pkg::OP_SUM);

  // The final beat of the burst is granted in this cycle
  assign last_beat = beat_fire && (beat_idx == cmd_q.len);

  // ####################
  // Next state
  // ####################

  always_comb begin
    state_d = state_q;
    case (state_q)
      ctrl_pkg::IDLE: begin
        if (cmd_req) begin
          state_d = ctrl_pkg::ISSUE;
        end
      end
      ctrl_pkg::ISSUE: begin
        // Writes have no responses to wait for
        if (last_beat) begin
          state_d = is_sum ? ctrl_pkg::DRAIN : ctrl_pkg::DONE;
        end
      end
      ctrl_pkg::DRAIN: begin
        if (drain_done) begin
          state_d = ctrl_pkg::DONE;
        end
      end
      ctrl_pkg::DONE: begin
        // Return to IDLE on the edge that also drops the acknowledge
        if (cmd_ack_q && !cmd_req) begin
          state_d = ctrl_pkg::IDLE;
        end
      end
      default: state_d = ctrl_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ctrl_pkg::IDLE;
      cmd_ack_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      // Acknowledge follows the request while the result is parked in DONE
      cmd_ack_q <= (state_q == ctrl_pkg::DONE) && cmd_req;
    end
  end

  // The command stays in this register for the whole burst
  always_ff @(posedge clk_i) begin
    if (start) begin
      cmd_q <= cmd;
    end
  end

  // ####################
  // TCDM request
  // ####################

  // Request is held unchanged while the bank withholds the grant, since the
  // counter only advances on a granted beat
  always_comb begin
    tcdm_req      = '0;
    tcdm_req.req  = (state_q == ctrl_pkg::ISSUE) && !issue_done;
    tcdm_req.wen  = is_sum;
    tcdm_req.add  = beat_addr;
    tcdm_req.data = is_sum ? '0 :
                    cmd_q.seed + {{(tcdm_pkg::DW-ctrl_pkg::LEN_W){1'b0}}, beat_idx};
    tcdm_req.user = cmd_q.tag;
  end

  assign beat_fire = tcdm_req.req && tcdm_rsp.gnt;
  assign rsp_fire  = tcdm_rsp.r_valid;

  // Clear pulses line up with the latch of a new command
  assign cnt_clear   = start;
  assign filt_clear  = start;
  // Only reads come back, so only reads need their tag recorded
  assign filt_enable = (state_q == ctrl_pkg::ISSUE) && is_sum;

  // ####################
  // Result
  // ####################

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_q <= '0;
    end else if (start) begin
      res_q <= '0;
    end else if (rsp_fire) begin
      res_q.sum      <= res_q.sum + tcdm_rsp.r_data;
      res_q.last_tag <= tcdm_rsp.r_user;
      // Sticky until the next command starts
      if (tcdm_rsp.r_user != cmd_q.tag) begin
        res_q.tag_err <= 1'b1;
      end
    end
  end

  assign res     = res_q;
  assign cmd_ack = cmd_ack_q;

endmodule

// File: ctrl_pkg.sv
package ctrl_pkg;

  // Beat count field holds the number of beats minus one
  localparam int unsigned LEN_W = 4;

  // Beat counters need one extra bit to hold the full count of 16
  localparam int unsigned CNT_W = LEN_W + 1;

  // ####################
  // Encodings
  // ####################

  // FILL writes a pattern, SUM reads and accumulates
  typedef enum logic [0:0] {
    OP_FILL,
    OP_SUM
  } cmd_op_e;

  // Engine sequencing states
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    DRAIN,
    DONE
  } fsm_state_e;

  // ####################
  // Command and result
  // ####################

  // Command as presented on the four-phase port
  typedef struct packed {
    cmd_op_e                      op;
    logic [tcdm_pkg::UW-1:0]      tag;
    logic [tcdm_pkg::AW-1:0]      addr;
    logic [LEN_W-1:0]             len;
    logic [tcdm_pkg::DW-1:0]      seed;
  } cmd_t;

  // Result returned while the acknowledge is high
  typedef struct packed {
    logic [tcdm_pkg::DW-1:0]      sum;
    logic [tcdm_pkg::UW-1:0]      last_tag;
    logic                         tag_err;
  } res_t;

endpackage

// File: src.f
tcdm_pkg.sv
ctrl_pkg.sv
tcdm_r_user_filter.sv
tcdm_bank.sv
burst_counter.sv
burst_fsm.sv
tcdm_burst_top.sv
tcdm_burst_sva.sv
tb_tcdm_burst.sv

// File: tb_tcdm_burst.sv
`timescale 1ns/1ns

module tb_tcdm_burst;

  // Cycles any single wait may take before the run is given up
  localparam int unsigned TIMEOUT = 100;

  logic           clk_i;
  logic           rst_ni;
  ctrl_pkg::cmd_t cmd;
  logic           cmd_req;
  logic           cmd_ack;
  ctrl_pkg::res_t res;

  // Mirror of the bank contents that every FILL updates
  logic [tcdm_pkg::DW-1:0] ref_mem [tcdm_pkg::MEM_WORDS];

  logic [15:0] lfsr_q;
  int unsigned err_cnt;
  int unsigned test_cnt;
  int unsigned fail_tests;
  int unsigned sva_fails;
  bit          timed_out;

  tcdm_burst_top u_tcdm_burst_top (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .cmd     (cmd),
    .cmd_req (cmd_req),
    .cmd_ack (cmd_ack),
    .res     (res)
  );

  // 4 ns clock
  always #2 clk_i = ~clk_i;

  // ####################
  // Helpers
  // ####################

  // Galois LFSR that steps once for every bit handed out
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic ctrl_pkg::cmd_t make_cmd(input ctrl_pkg::cmd_op_e op,
                                              input logic [31:0] tag,
                                              input logic [31:0] addr,
                                              input logic [31:0] len,
                                              input logic [31:0] seed);
    ctrl_pkg::cmd_t c;
    c.op   = op;
    c.tag  = tag[tcdm_pkg::UW-1:0];
    c.addr = addr[tcdm_pkg::AW-1:0];
    c.len  = len[ctrl_pkg::LEN_W-1:0];
    c.seed = seed;
    return c;
  endfunction

  // Sum of the mirrored words that a SUM over this range should see
  function automatic logic [31:0] model_sum(input ctrl_pkg::cmd_t c);
    logic [31:0] s;
    s = '0;
    for (int i = 0; i <= c.len; i++) begin
      s = s + ref_mem[(c.addr + i) % tcdm_pkg::MEM_WORDS];
    end
    return s;
  endfunction

  task automatic mirror_fill(input ctrl_pkg::cmd_t c);
    for (int i = 0; i <= c.len; i++) begin
      ref_mem[(c.addr + i) % tcdm_pkg::MEM_WORDS] = c.seed + i;
    end
  endtask

  // All driving and sampling happens 1 ns after the rising edge
  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    err_cnt++;
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout after %0d cycles while waiting for %s", TIMEOUT, what);
    timed_out = 1'b1;
    err_cnt++;
  endtask

  // ####################
  // Command port
  // ####################

  // A new request only goes out once the previous acknowledge is gone
  task automatic issue_cmd(input ctrl_pkg::cmd_t c);
    int unsigned n;
    for (n = 0; n < TIMEOUT && cmd_ack; n++) begin
      step();
    end
    if (cmd_ack) begin
      report_timeout("cmd_ack to fall before a new command");
      return;
    end
    cmd     = c;
    cmd_req = 1'b1;
  endtask

  task automatic wait_ack_high();
    int unsigned n;
    for (n = 0; n < TIMEOUT && !cmd_ack; n++) begin
      step();
    end
    if (!cmd_ack) begin
      report_timeout("cmd_ack to rise");
    end
  endtask

  task automatic release_cmd();
    int unsigned n;
    cmd_req = 1'b0;
    for (n = 0; n < TIMEOUT && cmd_ack; n++) begin
      step();
    end
    if (cmd_ack) begin
      report_timeout("cmd_ack to fall after cmd_req dropped");
    end
  endtask

  // Full four-phase exchange that takes the result while the acknowledge is high
  task automatic run_cmd(input ctrl_pkg::cmd_t c, output ctrl_pkg::res_t r);
    r = '0;
    issue_cmd(c);
    if (timed_out) return;
    wait_ack_high();
    if (timed_out) return;
    r = res;
    if (c.op == ctrl_pkg::OP_FILL) begin
      mirror_fill(c);
    end
    release_cmd();
  endtask

  task automatic check_sum(input ctrl_pkg::res_t r, input ctrl_pkg::cmd_t c,
                           input logic [31:0] exp);
    if (r.sum !== exp) report_mismatch("res.sum", r.sum, exp);
    if (r.last_tag !== c.tag) report_mismatch("res.last_tag", r.last_tag, c.tag);
    if (r.tag_err !== 1'b0) report_mismatch("res.tag_err", r.tag_err, 1'b0);
  endtask

  task automatic close_test(input string name, input int unsigned errs_at_start);
    test_cnt++;
    if (err_cnt == errs_at_start) begin
      $display("Test %s passed", name);
    end else begin
      fail_tests++;
      $display("Test %s failed with %0d errors", name, err_cnt - errs_at_start);
    end
  endtask

  // ####################
  // Tests
  // ####################

  // Bank comes out of reset cleared, so a full-length read adds to zero
  task automatic test_reset_sum();
    int unsigned    errs;
    ctrl_pkg::cmd_t c;
    ctrl_pkg::res_t r;
    errs = err_cnt;
    if (cmd_ack !== 1'b0) report_mismatch("cmd_ack", cmd_ack, 1'b0);
    c = make_cmd(ctrl_pkg::OP_SUM, rand_bits(4), 0, 15, 0);
    run_cmd(c, r);
    if (!timed_out) check_sum(r, c, 32'h0);
    close_test("reset_sum", errs);
  endtask

  // Each write is followed by a stalled cycle
  // The filled range then holds an arithmetic series
  task automatic test_fill_sum();
    int unsigned    errs;
    int unsigned    n;
    ctrl_pkg::cmd_t c;
    ctrl_pkg::res_t r;
    logic [31:0]    exp;
    errs = err_cnt;
    c = make_cmd(ctrl_pkg::OP_FILL, rand_bits(4), rand_bits(6), rand_bits(4), rand_bits(32));
    run_cmd(c, r);
    if (!timed_out && r.tag_err !== 1'b0) report_mismatch("res.tag_err", r.tag_err, 1'b0);
    n   = c.len + 1;
    exp = c.seed * n + (n * (n - 1)) / 2;
    c.op  = ctrl_pkg::OP_SUM;
    c.tag = c.tag + 1;
    if (!timed_out) run_cmd(c, r);
    if (!timed_out) check_sum(r, c, exp);
    close_test("fill_sum", errs);
  endtask

  // Random fills, then reads that overlap them and run past the top word
  task automatic test_random_wrap();
    int unsigned    errs;
    ctrl_pkg::cmd_t c;
    ctrl_pkg::res_t r;
    errs = err_cnt;
    for (int i = 0; i < 4 && !timed_out; i++) begin
      c = make_cmd(ctrl_pkg::OP_FILL, rand_bits(4), rand_bits(6), rand_bits(4),
                   rand_bits(32));
      run_cmd(c, r);
    end
    for (int i = 0; i < 6 && !timed_out; i++) begin
      if (i < 3) begin
        // Start in the top eight words with at least nine beats
        c = make_cmd(ctrl_pkg::OP_SUM, rand_bits(4), 56 + rand_bits(3), 8 + rand_bits(3), 0);
      end else begin
        c = make_cmd(ctrl_pkg::OP_SUM, rand_bits(4), rand_bits(6), rand_bits(4), 0);
      end
      run_cmd(c, r);
      if (!timed_out) check_sum(r, c, model_sum(c));
    end
    close_test("random_wrap", errs);
  endtask

  // Consecutive tags always differ so a stale filter register would show up
  task automatic test_tag_sequence();
    int unsigned    errs;
    ctrl_pkg::cmd_t c;
    ctrl_pkg::res_t r;
    errs = err_cnt;
    for (int i = 0; i < 6 && !timed_out; i++) begin
      c = make_cmd(ctrl_pkg::OP_SUM, 3 * i + 1, rand_bits(6), rand_bits(4), 0);
      run_cmd(c, r);
      if (!timed_out) check_sum(r, c, model_sum(c));
    end
    close_test("tag_sequence", errs);
  endtask

  // Acknowledge is held with the request and drops one cycle after it
  task automatic test_handshake();
    int unsigned    errs;
    ctrl_pkg::cmd_t c;
    ctrl_pkg::res_t r;
    logic [31:0]    exp;
    errs = err_cnt;
    c = make_cmd(ctrl_pkg::OP_FILL, 9, rand_bits(6), 0, rand_bits(32));
    run_cmd(c, r);
    exp = ref_mem[c.addr];
    c = make_cmd(ctrl_pkg::OP_SUM, 6, c.addr, 0, 0);
    if (!timed_out) issue_cmd(c);
    if (!timed_out) wait_ack_high();
    if (!timed_out) begin
      r = res;
      check_sum(r, c, exp);
      repeat (5) begin
        step();
        if (cmd_ack !== 1'b1) report_mismatch("cmd_ack", cmd_ack, 1'b1);
        if (res !== r) report_mismatch("res", res, r);
      end
      cmd_req = 1'b0;
      step();
      if (cmd_ack !== 1'b0) report_mismatch("cmd_ack", cmd_ack, 1'b0);
    end
    close_test("handshake", errs);
  endtask

  // ####################
  // Sequence
  // ####################

  initial begin
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    cmd        = '0;
    cmd_req    = 1'b0;
    lfsr_q     = 16'd30312;
    err_cnt    = 0;
    test_cnt   = 0;
    fail_tests = 0;
    sva_fails  = 0;
    timed_out  = 1'b0;
    for (int i = 0; i < tcdm_pkg::MEM_WORDS; i++) begin
      ref_mem[i] = '0;
    end
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    test_reset_sum();
    if (!timed_out) test_fill_sum();
    if (!timed_out) test_random_wrap();
    if (!timed_out) test_tag_sequence();
    if (!timed_out) test_handshake();

    // Failures of the bound assertions count as errors of the run
    sva_fails = u_tcdm_burst_top.u_top_checks.fail_cnt +
                u_tcdm_burst_top.u_filter.u_filter_checks.fail_cnt;
    if (sva_fails != 0) begin
      $display("Bound assertions failed %0d times", sva_fails);
      err_cnt += sva_fails;
    end

    $display("Tests run %0d, tests failed %0d, errors %0d", test_cnt, fail_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: tcdm_bank.sv
`timescale 1ns/1ns

module tcdm_bank (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  tcdm_pkg::tcdm_req_t req_in,
  output tcdm_pkg::tcdm_rsp_t rsp
);

  // Storage array, one entry per word
  logic [tcdm_pkg::DW-1:0] mem_q [tcdm_pkg::MEM_WORDS];

  logic                    gnt;
  logic                    rd_fire;
  logic                    wr_fire;
  logic                    wr_recover_q;
  logic                    r_valid_q;
  logic [tcdm_pkg::DW-1:0] r_data_q;

  // ####################
  // Grant
  // ####################

  // Every request is granted, except right after a granted write
  // The initiator holds its request through the stalled cycle
  assign gnt     = req_in.req & ~wr_recover_q;
  assign rd_fire = gnt & req_in.wen;
  assign wr_fire = gnt & ~req_in.wen;

  // Recovery flag and read valid, both one cycle behind the grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_recover_q <= 1'b0;
      r_valid_q    <= 1'b0;
    end else begin
      wr_recover_q <= wr_fire;
      r_valid_q    <= rd_fire;
    end
  end

  // ####################
  // Storage
  // ####################

  // The write lands on the grant edge
  // Contents come up cleared so a read before any fill returns zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < tcdm_pkg::MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_fire) begin
      mem_q[req_in.add] <= req_in.data;
    end
  end

  // Read data is captured on the grant edge and shown in the next cycle
  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      r_data_q <= mem_q[req_in.add];
    end
  end

  // The bank knows nothing about tags
  always_comb begin
    rsp         = '0;
    rsp.gnt     = gnt;
    rsp.r_valid = r_valid_q;
    rsp.r_data  = r_data_q;
    rsp.r_user  = '0;
  end

endmodule

// File: tcdm_burst_sva.sv
`timescale 1ns/1ns

module tcdm_burst_checks (
  input logic                clk_i,
  input logic                rst_ni,
  input tcdm_pkg::tcdm_req_t dn_req,
  input tcdm_pkg::tcdm_rsp_t dn_rsp,
  input logic                cmd_req,
  input logic                cmd_ack
);

  // A read transfers when request and grant meet with wen high
  logic rd_fire;

  // Number of assertion failures seen by this instance
  int unsigned fail_cnt = 0;

  assign rd_fire = dn_req.req && dn_rsp.gnt && dn_req.wen;

  // ####################
  // Latency boundary
  // ####################

  // The filter only lines up tags if every read answers exactly one cycle later
  rd_then_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_fire |=> dn_rsp.r_valid)
    else begin
      $error("r_valid missing in the cycle after a granted read");
      fail_cnt++;
    end

  // A response needs a granted read in the cycle before
  no_rd_no_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !rd_fire |=> !dn_rsp.r_valid)
    else begin
      $error("r_valid without a granted read in the previous cycle");
      fail_cnt++;
    end

  // ####################
  // Command handshake
  // ####################

  // Acknowledge only ever answers a pending request
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(cmd_ack) |-> $past(cmd_req))
    else begin
      $error("cmd_ack rose without cmd_req");
      fail_cnt++;
    end

  // Acknowledge holds while the request stays up and drops one cycle after it goes away
  ack_holds: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_ack && cmd_req |=> cmd_ack)
    else begin
      $error("cmd_ack fell while cmd_req was still high");
      fail_cnt++;
    end

  ack_falls: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_ack && !cmd_req |=> !cmd_ack)
    else begin
      $error("cmd_ack stayed high after cmd_req fell");
      fail_cnt++;
    end

endmodule

// Bank side of the filter with the handshake inputs tied off
bind tcdm_r_user_filter tcdm_burst_checks u_filter_checks (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .dn_req  (dn_req),
  .dn_rsp  (dn_rsp),
  .cmd_req (1'b0),
  .cmd_ack (1'b0)
);

// Command port of the top level with the TCDM inputs tied off
bind tcdm_burst_top tcdm_burst_checks u_top_checks (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .dn_req  ('0),
  .dn_rsp  ('0),
  .cmd_req (cmd_req),
  .cmd_ack (cmd_ack)
);

// File: tcdm_burst_top.sv
`timescale 1ns/1ns

module tcdm_burst_top (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  ctrl_pkg::cmd_t cmd,
  input  logic           cmd_req,
  output logic           cmd_ack,
  output ctrl_pkg::res_t res
);

  // ####################
  // Internal nets
  // ####################

  // Engine side and bank side of the r_user filter
  tcdm_pkg::tcdm_req_t        up_req;
  tcdm_pkg::tcdm_rsp_t        up_rsp;
  tcdm_pkg::tcdm_req_t        dn_req;
  tcdm_pkg::tcdm_rsp_t        dn_rsp;

  // Engine to counter and filter control
  logic                       cnt_clear;
  logic                       filt_clear;
  logic                       filt_enable;
  logic                       beat_fire;
  logic                       rsp_fire;
  logic [tcdm_pkg::AW-1:0]    beat_addr;
  logic [ctrl_pkg::LEN_W-1:0] beat_idx;
  logic                       issue_done;
  logic                       drain_done;

  // ####################
  // Blocks
  // ####################

  burst_fsm u_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd         (cmd),
    .cmd_req     (cmd_req),
    .cmd_ack     (cmd_ack),
    .res         (res),
    .tcdm_req    (up_req),
    .tcdm_rsp    (up_rsp),
    .cnt_clear   (cnt_clear),
    .filt_clear  (filt_clear),
    .filt_enable (filt_enable),
    .beat_fire   (beat_fire),
    .rsp_fire    (rsp_fire),
    .beat_addr   (beat_addr),
    .beat_idx    (beat_idx),
    .issue_done  (issue_done),
    .drain_done  (drain_done)
  );

  // Command fields stay put from cmd_req until cmd_ack, so the counter can
  // take address and length straight from the port
  burst_counter u_counter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear      (cnt_clear),
    .start_addr (cmd.addr),
    .len        (cmd.len),
    .beat_fire  (beat_fire),
    .rsp_fire   (rsp_fire),
    .beat_addr  (beat_addr),
    .beat_idx   (beat_idx),
    .issue_done (issue_done),
    .drain_done (drain_done)
  );

  // Sits right above the bank, where the read latency is one cycle
  tcdm_r_user_filter u_filter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clear  (filt_clear),
    .enable (filt_enable),
    .up_req (up_req),
    .up_rsp (up_rsp),
    .dn_req (dn_req),
    .dn_rsp (dn_rsp)
  );

  tcdm_bank u_bank (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_in (dn_req),
    .rsp    (dn_rsp)
  );

endmodule

// File: tcdm_pkg.sv
package tcdm_pkg;

  // ####################
  // Bank geometry
  // ####################

  // Word address width, enough to reach every word of the single bank
  localparam int unsigned AW = 6;

  // Data width of one TCDM word
  localparam int unsigned DW = 32;

  // Width of the user field, which carries the initiator tag
  localparam int unsigned UW = 4;

  // Number of words in the bank
  localparam int unsigned MEM_WORDS = 64;

  // ####################
  // Port bundles
  // ####################

  // Request side of the TCDM port
  // A wen of one marks a read, a wen of zero marks a write
  typedef struct packed {
    logic          req;
    logic          wen;
    logic [AW-1:0] add;
    logic [DW-1:0] data;
    logic [UW-1:0] user;
  } tcdm_req_t;

  // Response side of the TCDM port
  // The grant is combinational, the read data returns one cycle later
  typedef struct packed {
    logic          gnt;
    logic          r_valid;
    logic [DW-1:0] r_data;
    logic [UW-1:0] r_user;
  } tcdm_rsp_t;

endpackage

// File: tcdm_r_user_filter.sv
`timescale 1ns/1ns

module tcdm_r_user_filter (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear,
  input  logic                enable,
  input  tcdm_pkg::tcdm_req_t up_req,
  output tcdm_pkg::tcdm_rsp_t up_rsp,
  output tcdm_pkg::tcdm_req_t dn_req,
  input  tcdm_pkg::tcdm_rsp_t dn_rsp
);

  // Tag of the most recent enabled request
  logic [tcdm_pkg::UW-1:0] user_q;

  // ####################
  // Request path
  // ####################

  // Address, data, wen and req pass straight through
  // The bank below has no use for the tag, so it sees zero
  always_comb begin
    dn_req      = up_req;
    dn_req.user = '0;
  end

  // ####################
  // Response path
  // ####################

  // Grant, r_valid and r_data come back unchanged
  // The registered tag replaces whatever the bank drives on r_user
  always_comb begin
    up_rsp        = dn_rsp;
    up_rsp.r_user = user_q;
  end

  // The register is only correct at the one-cycle latency boundary
  // A read granted in one cycle gets its response in the next, exactly when
  // this register holds the tag that went with it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      user_q <= '0;
    end else if (clear) begin
      user_q <= '0;
    end else if (enable && up_req.req) begin
      user_q <= up_req.user;
    end
  end

endmodule
